// ==== bench/hdg_core_tb.sv ====
//////////////////////////////
// directed tests of the generator core, stops at the first mismatch
// register contents are never assumed after power-up, only after a write
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hdg_core_tb;

    localparam int BUS_TIMEOUT = 20;
    localparam int RAMP_CYCLES = 200;

    logic             clk_250mhz;
    logic             arst_n_i;
    logic             psel_i;
    logic             penable_i;
    logic             pwrite_i;
    hdg_pkg::addr_t   paddr_i;
    hdg_pkg::word_t   pwdata_i;
    hdg_pkg::strb_t   pstrb_i;
    logic             pready_o;
    hdg_pkg::word_t   prdata_o;
    logic             pslverr_o;
    hdg_pkg::sample_t dac_p1_d_o;
    hdg_pkg::sample_t dac_p2_d_o;
    hdg_pkg::sample_t dout_o;
    hdg_pkg::sync_t   sync_dac_o;

    integer seed;

    // expected ramp counter value
    hdg_pkg::sample_t ramp_ref;

    hdg_core dut0 (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pstrb_i    (pstrb_i),
        .pready_o   (pready_o),
        .prdata_o   (prdata_o),
        .pslverr_o  (pslverr_o),
        .dac_p1_d_o (dac_p1_d_o),
        .dac_p2_d_o (dac_p2_d_o),
        .dout_o     (dout_o),
        .sync_dac_o (sync_dac_o)
    );

    // 4 ns period
    always #2 clk_250mhz = ~clk_250mhz;

    // zero while in reset, then one step per clock
    always @(posedge clk_250mhz) begin
        if (!arst_n_i) begin
            ramp_ref <= '0;
        end else begin
            ramp_ref <= ramp_ref + 16'd1;
        end
    end

    //////////////////////////////
    // compare tasks
    task automatic cmp_word(input string what, input hdg_pkg::word_t exp,
                            input hdg_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, what, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic cmp_flag(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b got %b", $time, what, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic cmp_sample(input string what, input hdg_pkg::sample_t exp,
                              input hdg_pkg::sample_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, what, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic cmp_sync(input string what, input hdg_pkg::sync_t exp,
                            input hdg_pkg::sync_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, what, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // APB host
    // byte address of a control word
    function automatic hdg_pkg::addr_t win_addr(input logic [7:0] idx);
        return {20'hF0000, 2'b00, idx, 2'b00};
    endfunction

    // one transfer, setup then access until pready, response sampled mid-cycle
    task automatic bus_transfer(input bit write, input hdg_pkg::addr_t addr,
                                input hdg_pkg::word_t wdata, input hdg_pkg::strb_t strb,
                                output hdg_pkg::word_t rdata, output bit err);
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        @(posedge clk_250mhz);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        pstrb_i   <= strb;
        @(posedge clk_250mhz);
        penable_i <= 1'b1;
        while (!done) begin
            @(negedge clk_250mhz);
            if (pready_o === 1'b1) begin
                done  = 1'b1;
                rdata = prdata_o;
                err   = pslverr_o;
            end else begin
                cycles++;
                if (cycles > BUS_TIMEOUT) begin
                    $display("bus hung: no pready after %0d cycles at address %h", cycles, addr);
                    $display("TESTBENCH FAILED");
                    $fatal(1);
                end
            end
        end
        @(posedge clk_250mhz);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(input hdg_pkg::addr_t addr, input hdg_pkg::word_t data,
                             input hdg_pkg::strb_t strb, output bit err);
        hdg_pkg::word_t unused;
        bus_transfer(1'b1, addr, data, strb, unused, err);
    endtask

    task automatic apb_read(input hdg_pkg::addr_t addr, output hdg_pkg::word_t data,
                            output bit err);
        bus_transfer(1'b0, addr, '0, '0, data, err);
    endtask

    //////////////////////////////
    // tests
    task automatic reset_state_test();
        @(negedge clk_250mhz);
        cmp_flag("pready after reset", 1'b0, pready_o);
        cmp_flag("pslverr after reset", 1'b0, pslverr_o);
        cmp_sample("dout after reset", 16'd0, dout_o);
        cmp_sample("dac port 1 after reset", 16'd0, dac_p1_d_o);
        cmp_sample("dac port 2 after reset", 16'd0, dac_p2_d_o);
        cmp_sync("sync dac after reset", 8'd0, sync_dac_o);
    endtask

    task automatic write_read_test();
        logic [7:0]     idx;
        hdg_pkg::word_t data;
        hdg_pkg::word_t rd;
        bit             err;
        for (int i = 0; i < 12; i++) begin
            idx  = $random(seed);
            data = $random(seed);
            apb_write(win_addr(idx), data, 4'hF, err);
            cmp_flag("pslverr on window write", 1'b0, err);
            apb_read(win_addr(idx), rd, err);
            cmp_flag("pslverr on window read", 1'b0, err);
            cmp_word("read back", data, rd);
        end
    endtask

    task automatic byte_strobe_test();
        logic [7:0]     idx;
        hdg_pkg::word_t old_w;
        hdg_pkg::word_t new_w;
        hdg_pkg::word_t exp;
        hdg_pkg::word_t rd;
        hdg_pkg::strb_t strb;
        bit             err;
        for (int i = 0; i < 16; i++) begin
            idx   = $random(seed);
            old_w = (i == 0) ? 32'h1122_3344 : $random(seed);
            new_w = (i == 0) ? 32'hAABB_CCDD : $random(seed);
            strb  = (i == 0) ? 4'b0101 : i[3:0];
            // untouched lanes keep the old byte
            for (int lane = 0; lane < 4; lane++) begin
                exp[lane*8 +: 8] = strb[lane] ? new_w[lane*8 +: 8] : old_w[lane*8 +: 8];
            end
            apb_write(win_addr(idx), old_w, 4'hF, err);
            cmp_flag("pslverr on full write", 1'b0, err);
            apb_write(win_addr(idx), new_w, strb, err);
            cmp_flag("pslverr on strobed write", 1'b0, err);
            apb_read(win_addr(idx), rd, err);
            cmp_flag("pslverr on strobed read", 1'b0, err);
            cmp_word("strobed merge", exp, rd);
        end
    endtask

    task automatic out_of_window_test();
        hdg_pkg::word_t rd;
        bit             err;
        apb_write(win_addr(8'h03), 32'hC0DE_5A5A, 4'hF, err);
        cmp_flag("pslverr on setup write", 1'b0, err);
        // same low address bits in windows 0 and 1
        apb_write(32'h0000_000C, 32'hDEAD_BEEF, 4'hF, err);
        cmp_flag("pslverr on window 0 write", 1'b1, err);
        apb_write(32'h1000_000C, 32'hFEED_F00D, 4'hF, err);
        cmp_flag("pslverr on window 1 write", 1'b1, err);
        apb_read(32'h0000_000C, rd, err);
        cmp_flag("pslverr on window 0 read", 1'b1, err);
        apb_read(32'h1000_000C, rd, err);
        cmp_flag("pslverr on window 1 read", 1'b1, err);
        apb_read(win_addr(8'h03), rd, err);
        cmp_flag("pslverr on check read", 1'b0, err);
        cmp_word("register after missed writes", 32'hC0DE_5A5A, rd);
    endtask

    task automatic ramp_test();
        hdg_pkg::sample_t exp_p1;
        for (int i = 0; i < RAMP_CYCLES; i++) begin
            @(negedge clk_250mhz);
            // DAC ports hold the previous counter value
            exp_p1 = ramp_ref - 16'd1;
            cmp_sample("dout ramp", ramp_ref, dout_o);
            cmp_sample("dac port 1", exp_p1, dac_p1_d_o);
            cmp_sample("dac port 2", 16'd0 - exp_p1, dac_p2_d_o);
            cmp_sync("sync dac", ramp_ref[15:8], sync_dac_o);
        end
    endtask

    //////////////////////////////
    // sequence
    initial begin
        seed       = 29550;
        clk_250mhz = 1'b0;
        arst_n_i   = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        pstrb_i    = '0;
        repeat (3) @(posedge clk_250mhz);
        arst_n_i <= 1'b1;

        reset_state_test();
        ramp_test();
        write_read_test();
        byte_strobe_test();
        out_of_window_test();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/hdg_pkg.sv
verilog/reg_bus_if.sv
verilog/apb_reg_bridge.sv
verilog/ctrl_reg_ram.sv
verilog/ramp_dac_gen.sv
verilog/hdg_core.sv
bench/hdg_core_tb.sv

// ==== verilog/apb_reg_bridge.sv ====
//////////////////////////////
// APB4 slave, no wait on errors; window hits take one extra access cycle
// host must hold paddr, pwrite, pwdata and pstrb until pready
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "hdg_defines.svh"

module apb_reg_bridge (
    input  wire            clk_250mhz,
    input  wire            arst_n_i,

    // APB slave
    input  wire            psel_i,
    input  wire            penable_i,
    input  wire            pwrite_i,
    input  hdg_pkg::addr_t paddr_i,
    input  hdg_pkg::word_t pwdata_i,
    input  hdg_pkg::strb_t pstrb_i,
    output logic           pready_o,
    output hdg_pkg::word_t prdata_o,
    output logic           pslverr_o,

    // towards the register RAM
    reg_bus_if.bridge      bus
);

    hdg_pkg::apb_state_t state_q;
    hdg_pkg::apb_state_t state_d;
    logic                setup_phase;
    logic                win_hit;
    logic                err_q;
    logic                resp_done;

    // setup phase seen while idle launches the access
    assign setup_phase = psel_i && !penable_i;

    // the only place the address map is decoded
    assign win_hit = (paddr_i[`HDG_REGION_MSB:`HDG_REGION_LSB] == `HDG_CTRL_REGION);

    //////////////////////////////
    // sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            hdg_pkg::ST_IDLE: begin
                if (setup_phase && win_hit) begin
                    state_d = hdg_pkg::ST_REQ;
                end
            end
            // request goes out during the first access cycle
            hdg_pkg::ST_REQ: begin
                state_d = hdg_pkg::ST_WAIT;
            end
            hdg_pkg::ST_WAIT: begin
                if (bus.ack) begin
                    state_d = hdg_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = hdg_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= hdg_pkg::ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // misses complete in the first access cycle
            err_q   <= (state_q == hdg_pkg::ST_IDLE) && setup_phase && !win_hit;
        end
    end

    //////////////////////////////
    // register bus request
    // payload is taken straight from the held APB inputs
    assign bus.req   = (state_q == hdg_pkg::ST_REQ);
    assign bus.we    = pwrite_i;
    assign bus.idx   = paddr_i[`HDG_REG_IDX_W+1:2];
    assign bus.wdata = pwdata_i;
    assign bus.strb  = pstrb_i;

    //////////////////////////////
    // APB response
    assign resp_done = (state_q == hdg_pkg::ST_WAIT) && bus.ack;

    assign pready_o  = err_q || resp_done;
    assign pslverr_o = err_q;

    // read data passed through in the ack cycle, zero otherwise
    assign prdata_o  = (resp_done && !pwrite_i) ? bus.rdata : '0;

endmodule

`default_nettype wire

// ==== verilog/ctrl_reg_ram.sv ====
//////////////////////////////
// 256 x 32 control registers, contents undefined after power-up
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "hdg_defines.svh"

module ctrl_reg_ram (
    input  wire    clk_250mhz,
    input  wire    arst_n_i,

    reg_bus_if.ram bus
);

    localparam int LANE_W = `HDG_DATA_W / `HDG_STRB_W;
    localparam int DEPTH  = 1 << `HDG_REG_IDX_W;

    hdg_pkg::word_t mem [0:DEPTH-1];
    hdg_pkg::word_t rdata_q;
    logic           ack_q;

    //////////////////////////////
    // storage
    // lanes written independently under their strobe bit
    always_ff @(posedge clk_250mhz) begin
        if (bus.req) begin
            if (bus.we) begin
                for (int lane = 0; lane < `HDG_STRB_W; lane++) begin
                    if (bus.strb[lane]) begin
                        mem[bus.idx][lane*LANE_W +: LANE_W] <=
                            bus.wdata[lane*LANE_W +: LANE_W];
                    end
                end
            end
            // old contents on a write, not looked at by the bridge
            rdata_q <= mem[bus.idx];
        end
    end

    //////////////////////////////
    // handshake
    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.req;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

// ==== verilog/hdg_core.sv ====
//////////////////////////////
// generator core, single clock domain
// host access through APB, control window at F0000000 only
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hdg_core (
    input  wire              clk_250mhz,
    input  wire              arst_n_i,

    // host APB
    input  wire              psel_i,
    input  wire              penable_i,
    input  wire              pwrite_i,
    input  hdg_pkg::addr_t   paddr_i,
    input  hdg_pkg::word_t   pwdata_i,
    input  hdg_pkg::strb_t   pstrb_i,
    output logic             pready_o,
    output hdg_pkg::word_t   prdata_o,
    output logic             pslverr_o,

    // main DAC
    output hdg_pkg::sample_t dac_p1_d_o,
    output hdg_pkg::sample_t dac_p2_d_o,

    // digital output
    output hdg_pkg::sample_t dout_o,

    // sync DAC
    output hdg_pkg::sync_t   sync_dac_o
);

    //////////////////////////////
    // host control path

    // bridge to register RAM
    reg_bus_if rbus0 ();

    apb_reg_bridge bridge0 (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .pstrb_i    (pstrb_i),
        .pready_o   (pready_o),
        .prdata_o   (prdata_o),
        .pslverr_o  (pslverr_o),
        .bus        (rbus0.bridge)
    );

    ctrl_reg_ram regs0 (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .bus        (rbus0.ram)
    );

    //////////////////////////////
    // test waveform path

    ramp_dac_gen ramp0 (
        .clk_250mhz (clk_250mhz),
        .arst_n_i   (arst_n_i),
        .dac_p1_d_o (dac_p1_d_o),
        .dac_p2_d_o (dac_p2_d_o),
        .dout_o     (dout_o),
        .sync_dac_o (sync_dac_o)
    );

endmodule

`default_nettype wire

// ==== verilog/hdg_defines.svh ====
//////////////////////////////
// widths and the address map of the host bus
// only the F window is decoded; all other windows answer with an error
//////////////////////////////
`ifndef HDG_DEFINES_SVH
`define HDG_DEFINES_SVH

// register bus
`define HDG_DATA_W      32
`define HDG_ADDR_W      32
`define HDG_STRB_W      4

// 256 control words
`define HDG_REG_IDX_W   8

// waveform outputs
`define HDG_SAMPLE_W    16
`define HDG_SYNC_W      8

// window select nibble of the byte address
`define HDG_REGION_MSB  31
`define HDG_REGION_LSB  28
`define HDG_CTRL_REGION 4'hF

`endif

// ==== verilog/hdg_pkg.sv ====
//////////////////////////////
// shared types of the core, sized from the defines header
//////////////////////////////
`default_nettype none

`include "hdg_defines.svh"

package hdg_pkg;

    // host bus
    typedef logic [`HDG_DATA_W-1:0]    word_t;
    typedef logic [`HDG_ADDR_W-1:0]    addr_t;
    typedef logic [`HDG_STRB_W-1:0]    strb_t;
    typedef logic [`HDG_REG_IDX_W-1:0] reg_idx_t;

    // waveform path
    typedef logic [`HDG_SAMPLE_W-1:0]  sample_t;
    typedef logic [`HDG_SYNC_W-1:0]    sync_t;

    // APB bridge sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } apb_state_t;

endpackage

`default_nettype wire

// ==== verilog/ramp_dac_gen.sv ====
//////////////////////////////
// free-running test ramp, no back-pressure
// DAC ports lag dout and sync by one cycle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "hdg_defines.svh"

module ramp_dac_gen (
    input  wire              clk_250mhz,
    input  wire              arst_n_i,

    // main DAC data ports
    output hdg_pkg::sample_t dac_p1_d_o,
    output hdg_pkg::sample_t dac_p2_d_o,

    // digital output and sync DAC
    output hdg_pkg::sample_t dout_o,
    output hdg_pkg::sync_t   sync_dac_o
);

    hdg_pkg::sample_t count_q;
    hdg_pkg::sample_t dac_p1_q;
    hdg_pkg::sample_t dac_p2_q;

    //////////////////////////////
    // stage one, ramp counter
    // wraps naturally at the sample width
    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    //////////////////////////////
    // stage two, DAC output registers
    always_ff @(posedge clk_250mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dac_p1_q <= '0;
            dac_p2_q <= '0;
        end else begin
            dac_p1_q <= count_q;
            // port 2 gets the mirrored ramp
            dac_p2_q <= -count_q;
        end
    end

    assign dac_p1_d_o = dac_p1_q;
    assign dac_p2_d_o = dac_p2_q;

    // taken from the counter stage
    assign dout_o     = count_q;
    assign sync_dac_o = count_q[`HDG_SAMPLE_W-1 -: `HDG_SYNC_W];

endmodule

`default_nettype wire

// ==== verilog/reg_bus_if.sv ====
//////////////////////////////
// single-beat register bus, one request in flight at a time
// ack follows req by exactly one cycle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

    // request side
    logic              req;
    logic              we;
    hdg_pkg::reg_idx_t idx;
    hdg_pkg::word_t    wdata;
    hdg_pkg::strb_t    strb;

    // response side, rdata only meaningful while ack is high
    hdg_pkg::word_t    rdata;
    logic              ack;

    modport bridge (
        output req,
        output we,
        output idx,
        output wdata,
        output strb,
        input  rdata,
        input  ack
    );

    modport ram (
        input  req,
        input  we,
        input  idx,
        input  wdata,
        input  strb,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire
